// File: src/pcs_tx_pkg.sv
// Shared widths, character codes, block formats and types for the 64b/66b transmit PCS
package pcs_tx_pkg;

	// Widths fixed by the standard
	localparam int NB_BYTES     = 8;
	localparam int NB_CHAR      = 8;
	localparam int NB_PCS_CHAR  = 7;
	localparam int NB_DATA_RAW  = NB_BYTES * NB_CHAR;
	localparam int NB_SH        = 2;
	localparam int N_BLOCK_TYPE = 5 + NB_BYTES;

	typedef logic [NB_DATA_RAW-1:0] cgmii_data_t;
	typedef logic [NB_BYTES-1:0]    cgmii_ctrl_t;
	typedef logic [NB_CHAR-1:0]     cgmii_char_t;
	typedef logic [NB_PCS_CHAR-1:0] pcs_char_t;
	typedef logic [NB_SH-1:0]       sync_header_t;
	typedef logic [NB_DATA_RAW-1:0] block_payload_t;

	// CGMII control characters
	localparam cgmii_char_t CGMII_START     = 8'hFB;
	localparam cgmii_char_t CGMII_TERMINATE = 8'hFD;
	localparam cgmii_char_t CGMII_SIGNAL    = 8'h5C;
	localparam cgmii_char_t CGMII_SEQUENCE  = 8'h9C;
	localparam cgmii_char_t CGMII_IDLE      = 8'h07;
	localparam cgmii_char_t CGMII_ERROR     = 8'hFE;

	// PCS control codes
	localparam pcs_char_t   PCS_IDLE      = 7'h00;
	localparam pcs_char_t   PCS_ERROR     = 7'h1E;
	localparam logic [3:0]  PCS_ORDER_SEQ = 4'h0;
	localparam logic [3:0]  PCS_ORDER_SIG = 4'hF;

	localparam sync_header_t DATA_SH = 2'b01;
	localparam sync_header_t CTRL_SH = 2'b10;

	// Block type field values
	localparam cgmii_char_t BTYPE_CTRL  = 8'h1E;
	localparam cgmii_char_t BTYPE_S     = 8'h78;
	localparam cgmii_char_t BTYPE_ORDER = 8'h4B;
	localparam cgmii_char_t BTYPE_T0    = 8'h87;
	localparam cgmii_char_t BTYPE_T1    = 8'h99;
	localparam cgmii_char_t BTYPE_T2    = 8'hAA;
	localparam cgmii_char_t BTYPE_T3    = 8'hB4;
	localparam cgmii_char_t BTYPE_T4    = 8'hCC;
	localparam cgmii_char_t BTYPE_T5    = 8'hD2;
	localparam cgmii_char_t BTYPE_T6    = 8'hE1;
	localparam cgmii_char_t BTYPE_T7    = 8'hFF;

	// Terminate types indexed by terminate position
	localparam cgmii_char_t BTYPE_TERM [NB_BYTES] = '{
		BTYPE_T0, BTYPE_T1, BTYPE_T2, BTYPE_T3,
		BTYPE_T4, BTYPE_T5, BTYPE_T6, BTYPE_T7
	};

	typedef struct packed {
		sync_header_t   header;
		block_payload_t payload;
	} pcs_block_t;

	// Same order as T_TYPE in the standard
	typedef struct packed {
		logic is_data;
		logic is_start;
		logic is_control;
		logic is_terminate;
	} block_class_t;

	typedef enum logic [2:0] {TX_INIT, TX_C, TX_D, TX_T, TX_E} tx_state_t;

	localparam pcs_block_t ERROR_BLOCK = '{
		header:  CTRL_SH,
		payload: {BTYPE_CTRL, {NB_BYTES{PCS_ERROR}}}
	};

	// Scrambler polynomial 1 + x^39 + x^58
	localparam int SCRAMBLER_LEN = 58;
	localparam int SCRAMBLER_TAP = 38;

endpackage

// File: src/encoder_comparator.sv
// Classifies a registered CGMII word and builds its 66-bit coded block and block class
`timescale 1ns/1ns

module encoder_comparator (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_tx_pkg::cgmii_data_t  i_tx_data,
	input  pcs_tx_pkg::cgmii_ctrl_t  i_tx_ctrl,
	output logic                     o_valid,
	output pcs_tx_pkg::pcs_block_t   o_block,
	output pcs_tx_pkg::block_class_t o_class
);
	import pcs_tx_pkg::*;

	cgmii_data_t             tx_data;
	cgmii_ctrl_t             tx_ctrl;
	logic                    valid_q;
	cgmii_char_t             in_char [NB_BYTES];
	pcs_char_t               pcs_char [NB_BYTES];
	logic [NB_BYTES-1:0]     valid_char;
	logic                    type_data;
	logic                    type_s;
	logic                    type_q;
	logic                    type_fsig;
	logic                    type_idle;
	logic [NB_BYTES-1:0]     type_term;
	logic [N_BLOCK_TYPE-1:0] deco_type;
	block_payload_t          term_payload [NB_BYTES];

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			valid_q <= 1'b0;
		else
			valid_q <= i_valid;
	end

	// Word held until the next accepted one
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			tx_data <= i_tx_data;
			tx_ctrl <= i_tx_ctrl;
		end
	end

	// Split into characters, byte 0 at the top; only idle and error map to PCS codes
	always_comb
	begin
		for (int i = 0; i < NB_BYTES; i++)
		begin
			in_char[i] = tx_data[NB_DATA_RAW-1-NB_CHAR*i -: NB_CHAR];
			case (in_char[i])
				CGMII_IDLE:
				begin
					pcs_char[i]   = PCS_IDLE;
					valid_char[i] = 1'b1;
				end
				CGMII_ERROR:
				begin
					pcs_char[i]   = PCS_ERROR;
					valid_char[i] = 1'b1;
				end
				default:
				begin
					pcs_char[i]   = PCS_ERROR;
					valid_char[i] = 1'b0;
				end
			endcase
		end
	end

	assign type_data = (tx_ctrl == 8'h00);
	assign type_s    = (tx_ctrl == 8'h80) && (in_char[0] == CGMII_START);
	assign type_q    = (tx_ctrl == 8'h80) && (in_char[0] == CGMII_SEQUENCE);
	assign type_fsig = (tx_ctrl == 8'h80) && (in_char[0] == CGMII_SIGNAL);
	assign type_idle = (tx_ctrl == 8'hFF) && (tx_data == {NB_BYTES{CGMII_IDLE}});

	// Terminate at n: control flags from byte n on, every character after it idle or error
	for (genvar n = 0; n < NB_BYTES; n++)
	begin : g_term
		localparam cgmii_ctrl_t         TERM_CTRL = cgmii_ctrl_t'(8'hFF >> n);
		localparam logic [NB_BYTES-1:0] TAIL_MASK = NB_BYTES'(8'hFF << (n + 1));

		assign type_term[n] = (tx_ctrl == TERM_CTRL) && (in_char[n] == CGMII_TERMINATE)
			&& (&(valid_char | ~TAIL_MASK));
	end

	// Type byte, data before /T/, zero pad, mapped tail with char 7 lowest
	always_comb
	begin
		for (int n = 0; n < NB_BYTES; n++)
		begin
			term_payload[n] = '0;
			term_payload[n][NB_DATA_RAW-1 -: NB_CHAR] = BTYPE_TERM[n];
			for (int i = 0; i < n; i++)
				term_payload[n][NB_DATA_RAW-1-NB_CHAR*(i+1) -: NB_CHAR] = in_char[i];
			for (int j = n + 1; j < NB_BYTES; j++)
				term_payload[n][NB_PCS_CHAR*(NB_BYTES-j)-1 -: NB_PCS_CHAR] = pcs_char[j];
		end
	end

	assign deco_type = {type_data, type_s, type_q, type_fsig, type_idle, type_term};

	always_comb
	begin
		o_block = ERROR_BLOCK;
		if (type_data)
			o_block = '{header: DATA_SH, payload: tx_data};
		else if (type_s)
			o_block = '{header: CTRL_SH, payload: {BTYPE_S, tx_data[NB_DATA_RAW-NB_CHAR-1:0]}};
		else if (type_q || type_fsig)
		begin
			o_block.header  = CTRL_SH;
			o_block.payload = {BTYPE_ORDER, tx_data[NB_DATA_RAW-NB_CHAR-1 -: 24],
				type_q ? PCS_ORDER_SEQ : PCS_ORDER_SIG, 28'h0};
		end
		else if (type_idle)
			o_block = '{header: CTRL_SH, payload: {BTYPE_CTRL, {NB_BYTES{PCS_IDLE}}}};
		else
		begin
			for (int n = 0; n < NB_BYTES; n++)
				if (type_term[n])
					o_block = '{header: CTRL_SH, payload: term_payload[n]};
		end
	end

	// T_TYPE for the transmit FSM
	assign o_class = '{
		is_data:      type_data,
		is_start:     type_s,
		is_control:   type_q | type_fsig | type_idle,
		is_terminate: |type_term
	};

	assign o_valid = valid_q;

	// A word never matches two formats
	assert property (@(posedge i_clock) disable iff (i_reset)
		valid_q |-> $onehot0(deco_type));

endmodule

// File: src/tx_encode_fsm.sv
// Transmit block-order FSM, replaces blocks in an illegal position with the error block
`timescale 1ns/1ns

module tx_encode_fsm (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_tx_pkg::pcs_block_t   i_block,
	input  pcs_tx_pkg::block_class_t i_class,
	output logic                     o_valid,
	output pcs_tx_pkg::pcs_block_t   o_block
);
	import pcs_tx_pkg::*;

	tx_state_t state;
	tx_state_t next_state;

	// Anything not listed falls to TX_E
	always_comb
	begin
		next_state = TX_E;
		case (state)
			TX_INIT, TX_C, TX_T:
			begin
				if (i_class.is_control)
					next_state = TX_C;
				else if (i_class.is_start)
					next_state = TX_D;
			end
			TX_D:
			begin
				if (i_class.is_data)
					next_state = TX_D;
				else if (i_class.is_terminate)
					next_state = TX_T;
			end
			TX_E:
			begin
				if (i_class.is_data)
					next_state = TX_D;
				else if (i_class.is_terminate)
					next_state = TX_T;
				else if (i_class.is_control)
					next_state = TX_C;
			end
			default:
				next_state = TX_E;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= TX_INIT;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
				state <= next_state;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			if (next_state == TX_E)
				o_block <= ERROR_BLOCK;
			else
				o_block <= i_block;
		end
	end

	// Comparator gives at most one class per block
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_valid |-> $onehot0(i_class));

endmodule

// File: src/block_scrambler.sv
// Self-synchronizing 1 + x^39 + x^58 payload scrambler with registered output
`timescale 1ns/1ns

module block_scrambler (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_valid,
	input  pcs_tx_pkg::pcs_block_t i_block,
	output logic                   o_valid,
	output pcs_tx_pkg::pcs_block_t o_block
);
	import pcs_tx_pkg::*;

	logic [SCRAMBLER_LEN-1:0] scr_state;
	logic [SCRAMBLER_LEN-1:0] scr_next;
	block_payload_t           scr_payload;
	logic                     scr_bit;

	// Bit 0 goes first, each scrambled bit feeds back into the state
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < NB_DATA_RAW; i++)
		begin
			scr_bit = i_block.payload[i] ^ scr_next[SCRAMBLER_TAP] ^ scr_next[SCRAMBLER_LEN-1];
			scr_payload[i] = scr_bit;
			scr_next = {scr_next[SCRAMBLER_LEN-2:0], scr_bit};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid   <= 1'b0;
			scr_state <= '0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
				scr_state <= scr_next;
		end
	end

	// Sync header is sent in the clear
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
			o_block <= '{header: i_block.header, payload: scr_payload};
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |-> (o_block.header == DATA_SH) || (o_block.header == CTRL_SH));

endmodule

// File: src/pcs_tx_top.sv
// Transmit PCS top, chains block encoding, block-order FSM and scrambler
`timescale 1ns/1ns

module pcs_tx_top (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_valid,
	input  pcs_tx_pkg::cgmii_data_t i_tx_data,
	input  pcs_tx_pkg::cgmii_ctrl_t i_tx_ctrl,
	output logic                    o_valid,
	output pcs_tx_pkg::pcs_block_t  o_block
);
	import pcs_tx_pkg::*;

	logic         enc_valid;
	pcs_block_t   enc_block;
	block_class_t enc_class;
	logic         fsm_valid;
	pcs_block_t   fsm_block;

	encoder_comparator encoder_comparator_inst (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_tx_data (i_tx_data),
		.i_tx_ctrl (i_tx_ctrl),
		.o_valid   (enc_valid),
		.o_block   (enc_block),
		.o_class   (enc_class)
	);

	// Order check one cycle after encoding
	tx_encode_fsm tx_encode_fsm_inst (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (enc_valid),
		.i_block (enc_block),
		.i_class (enc_class),
		.o_valid (fsm_valid),
		.o_block (fsm_block)
	);

	block_scrambler block_scrambler_inst (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (fsm_valid),
		.i_block (fsm_block),
		.o_valid (o_valid),
		.o_block (o_block)
	);

endmodule

// File: bench/tb_pcs_tx.sv
// Transmit PCS testbench that checks LFSR-driven CGMII words against a reference model
`timescale 1ns/1ns

module tb_pcs_tx;
	import pcs_tx_pkg::*;

	localparam int K_DATA  = 0;
	localparam int K_START = 1;
	localparam int K_ORDER = 2;
	localparam int K_IDLE  = 3;
	localparam int K_TERM  = 4;
	localparam int K_JUNK  = 5;

	logic        i_clock;
	logic        i_reset;
	logic        i_valid;
	cgmii_data_t i_tx_data;
	cgmii_ctrl_t i_tx_ctrl;
	logic        o_valid;
	pcs_block_t  o_block;

	logic [15:0]              lfsr_q;
	logic [SCRAMBLER_LEN-1:0] model_scr;
	tx_state_t                model_state;
	pcs_block_t               exp_blocks[$];
	int                       exp_cycles[$];
	int                       cycle = 0;

	pcs_tx_top pcs_tx_top_inst (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_tx_data (i_tx_data),
		.i_tx_ctrl (i_tx_ctrl),
		.o_valid   (o_valid),
		.o_block   (o_block)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	always @(posedge i_clock)
		cycle <= cycle + 1;

	// x^16 + x^15 + x^13 + x^4 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[62:0], lfsr_q[0]};
		end
		return r;
	endfunction

	task automatic make_word(input int kind, input int pos,
		output cgmii_data_t d, output cgmii_ctrl_t c);
		d = rand_bits(64);
		c = 8'h00;
		case (kind)
			K_START:
			begin
				c = 8'h80;
				d[63:56] = CGMII_START;
			end
			K_ORDER:
			begin
				c = 8'h80;
				d[63:56] = (rand_bits(1) != 0) ? CGMII_SIGNAL : CGMII_SEQUENCE;
			end
			K_IDLE:
			begin
				c = 8'hFF;
				d = {8{CGMII_IDLE}};
			end
			K_TERM:
			begin
				c = 8'hFF >> pos;
				d[63-8*pos -: 8] = CGMII_TERMINATE;
				for (int j = pos + 1; j < 8; j++)
					d[63-8*j -: 8] = (rand_bits(1) != 0) ? CGMII_ERROR : CGMII_IDLE;
			end
			K_JUNK: c = cgmii_ctrl_t'(rand_bits(8)) | 8'h01;
			default: c = 8'h00;
		endcase
	endtask

	function automatic pcs_char_t map_char(input cgmii_char_t ch);
		return (ch == CGMII_IDLE) ? PCS_IDLE : PCS_ERROR;
	endfunction

	// Block formats of the 64b/66b code with byte 0 in the top byte
	task automatic encode_word(input cgmii_data_t d, input cgmii_ctrl_t c,
		output pcs_block_t blk, output block_class_t cls);
		cgmii_char_t ch [8];
		logic        tail_ok;
		blk = ERROR_BLOCK;
		cls = '0;
		for (int i = 0; i < 8; i++)
			ch[i] = d[63-8*i -: 8];
		if (c == 8'h00)
		begin
			blk = {DATA_SH, d};
			cls.is_data = 1'b1;
		end
		else if (c == 8'h80 && ch[0] == CGMII_START)
		begin
			blk = {CTRL_SH, BTYPE_S, d[55:0]};
			cls.is_start = 1'b1;
		end
		else if (c == 8'h80 && (ch[0] == CGMII_SEQUENCE || ch[0] == CGMII_SIGNAL))
		begin
			blk = {CTRL_SH, BTYPE_ORDER, d[55:32],
				(ch[0] == CGMII_SEQUENCE) ? PCS_ORDER_SEQ : PCS_ORDER_SIG, 28'h0};
			cls.is_control = 1'b1;
		end
		else if (c == 8'hFF && d == {8{CGMII_IDLE}})
		begin
			blk = {CTRL_SH, BTYPE_CTRL, 56'h0};
			cls.is_control = 1'b1;
		end
		else
		begin
			for (int n = 0; n < 8; n++)
			begin
				tail_ok = 1'b1;
				for (int j = n + 1; j < 8; j++)
					tail_ok &= (ch[j] == CGMII_IDLE || ch[j] == CGMII_ERROR);
				if (c == (8'hFF >> n) && ch[n] == CGMII_TERMINATE && tail_ok)
				begin
					// Data before /T/ and then 7-bit codes packed at the bottom with C7 lowest
					blk = {CTRL_SH, BTYPE_TERM[n], 56'h0};
					for (int i = 0; i < n; i++)
						blk.payload[55-8*i -: 8] = ch[i];
					for (int j = n + 1; j < 8; j++)
						blk.payload[7*(8-j)-1 -: 7] = map_char(ch[j]);
					cls.is_terminate = 1'b1;
				end
			end
		end
	endtask

	function automatic tx_state_t next_tx_state(input tx_state_t s, input block_class_t k);
		case (s)
			TX_D: return k.is_data ? TX_D : k.is_terminate ? TX_T : TX_E;
			TX_E: return k.is_data ? TX_D : k.is_terminate ? TX_T : k.is_control ? TX_C : TX_E;
			default: return k.is_control ? TX_C : k.is_start ? TX_D : TX_E;
		endcase
	endfunction

	// Bit 0 first and each scrambled bit shifted back into the state
	function automatic block_payload_t scramble_payload(input block_payload_t p);
		block_payload_t s;
		logic           b;
		for (int i = 0; i < 64; i++)
		begin
			b = p[i] ^ model_scr[38] ^ model_scr[SCRAMBLER_LEN-1];
			s[i] = b;
			model_scr = {model_scr[SCRAMBLER_LEN-2:0], b};
		end
		return s;
	endfunction

	task automatic send_word(input int kind, input int pos);
		cgmii_data_t  d;
		cgmii_ctrl_t  c;
		pcs_block_t   blk;
		block_class_t cls;
		@(negedge i_clock);
		make_word(kind, pos, d, c);
		i_valid = 1'b1;
		i_tx_data = d;
		i_tx_ctrl = c;
		encode_word(d, c, blk, cls);
		model_state = next_tx_state(model_state, cls);
		if (model_state == TX_E)
			blk = ERROR_BLOCK;
		blk.payload = scramble_payload(blk.payload);
		exp_blocks.push_back(blk);
		// Three register stages from the next rising edge on
		exp_cycles.push_back(cycle + 3);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge i_clock);
			i_valid = 1'b0;
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_block(input string name, input pcs_block_t got, input pcs_block_t exp);
		if (got.header !== exp.header)
			stop_run($sformatf("Mismatch at %0t ns: %s.header got %b expected %b",
				$time, name, got.header, exp.header));
		else if (got.payload !== exp.payload)
			stop_run($sformatf("Mismatch at %0t ns: %s.payload got %h expected %h",
				$time, name, got.payload, exp.payload));
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	always @(negedge i_clock)
	begin
		if (o_valid !== 1'b0)
		begin
			if (exp_blocks.size() == 0)
				stop_run("o_valid went high while no block was expected");
			else
			begin
				check_latency("o_valid cycle", cycle, exp_cycles.pop_front());
				check_block("o_block", o_block, exp_blocks.pop_front());
			end
		end
	end

	initial
	begin
		int wait_cnt;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_tx_data = '0;
		i_tx_ctrl = '0;
		lfsr_q = 16'd59;
		model_state = TX_INIT;
		model_scr = '0;
		repeat (16) @(negedge i_clock);
		i_reset = 1'b0;
		idle_cycles(4);

		// Legal frames with every terminate position and an ordered set between frames
		for (int n = 0; n < 8; n++)
		begin
			send_word(K_IDLE, 0);
			send_word(K_START, 0);
			send_word(K_DATA, 0);
			send_word(K_TERM, n);
			send_word(K_ORDER, 0);
		end

		// Data after control, start while in error, start inside a frame, junk word
		send_word(K_DATA, 0);
		send_word(K_START, 0);
		send_word(K_IDLE, 0);
		send_word(K_START, 0);
		send_word(K_START, 0);
		send_word(K_DATA, 0);
		send_word(K_JUNK, 0);
		send_word(K_TERM, 3);
		send_word(K_IDLE, 0);

		repeat (600)
		begin
			if (rand_bits(2) == 0)
				idle_cycles(int'(rand_bits(2)) + 1);
			case (rand_bits(3))
				0, 1: send_word(K_DATA, 0);
				2: send_word(K_START, 0);
				3: send_word(K_ORDER, 0);
				4: send_word(K_IDLE, 0);
				5, 6: send_word(K_TERM, int'(rand_bits(3)));
				default: send_word(K_JUNK, 0);
			endcase
		end

		idle_cycles(1);
		wait_cnt = 0;
		while (exp_blocks.size() != 0 && wait_cnt < 10)
		begin
			@(negedge i_clock);
			wait_cnt++;
		end
		idle_cycles(4);
		if (exp_blocks.size() != 0)
			stop_run("Expected blocks were still missing when the output timeout ran out");
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// File: sim.f
src/pcs_tx_pkg.sv
src/encoder_comparator.sv
src/tx_encode_fsm.sv
src/block_scrambler.sv
src/pcs_tx_top.sv
bench/tb_pcs_tx.sv

// File: Bender.yml
package:
  name: pcs_tx

sources:
  - src/pcs_tx_pkg.sv
  - src/encoder_comparator.sv
  - src/tx_encode_fsm.sv
  - src/block_scrambler.sv
  - src/pcs_tx_top.sv
  - target: test
    files:
      - bench/tb_pcs_tx.sv
